// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] reg_value_t;
    typedef logic [31:0] instr_t;

    // Major opcodes supported by this RV32I subset
    typedef enum logic [6:0] {
        RV_OP     = 7'b0110011,
        RV_OP_IMM = 7'b0010011,
        RV_LUI    = 7'b0110111,
        RV_AUIPC  = 7'b0010111,
        RV_BRANCH = 7'b1100011,
        RV_JAL    = 7'b1101111,
        RV_JALR   = 7'b1100111,
        RV_LOAD   = 7'b0000011,
        RV_STORE  = 7'b0100011,
        RV_SYSTEM = 7'b1110011
    } opcode_t;

    localparam instr_t EBREAK_INSTR = 32'h0010_0073;

    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rd;
        logic [2:0] funct3;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [6:0] funct7;
    } rv_fields_t;

    function automatic rv_fields_t get_fields(input instr_t instr);
        rv_fields_t f;
        f.opcode = opcode_t'(instr[6:0]);
        f.rd     = instr[11:7];
        f.funct3 = instr[14:12];
        f.rs1    = instr[19:15];
        f.rs2    = instr[24:20];
        f.funct7 = instr[31:25];
        return f;
    endfunction

    // Sign-extended immediate, selected by the format the opcode implies
    function automatic reg_value_t get_immediate(input instr_t instr);
        case (opcode_t'(instr[6:0]))
            RV_OP_IMM, RV_LOAD, RV_JALR:
                return {{20{instr[31]}}, instr[31:20]};
            RV_STORE:
                return {{20{instr[31]}}, instr[31:25], instr[11:7]};
            RV_BRANCH:
                return {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            RV_LUI, RV_AUIPC:
                return {instr[31:12], 12'b0};
            RV_JAL:
                return {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                return '0;
        endcase
    endfunction

    function automatic logic uses_rs1(input rv_fields_t f);
        return f.opcode inside {RV_OP, RV_OP_IMM, RV_BRANCH, RV_JALR, RV_LOAD, RV_STORE};
    endfunction

    function automatic logic uses_rs2(input rv_fields_t f);
        return f.opcode inside {RV_OP, RV_BRANCH, RV_STORE};
    endfunction

    // x0 never counts as a destination
    function automatic logic writes_rd(input rv_fields_t f);
        return (f.rd != '0) &&
               (f.opcode inside {RV_OP, RV_OP_IMM, RV_LUI, RV_AUIPC, RV_JAL, RV_JALR, RV_LOAD});
    endfunction

endpackage

// ==== decode_pkg.sv ====
package decode_pkg;

    import rv_isa_pkg::*;

    localparam int JUMP_FLAG_WIDTH = 2;
    typedef logic [JUMP_FLAG_WIDTH-1:0] jump_flag_t;

    localparam int REG_STATUS_WIDTH = 3;
    typedef logic [REG_STATUS_WIDTH-1:0] reg_status_t;

    localparam int NUM_REGS = 32;

    typedef enum logic [1:0] {
        DECODE_RESET,
        DECODE_NORMAL,
        DECODE_EXIT
    } decode_state_t;

    typedef enum logic [1:0] {
        EXEC_ALU,
        EXEC_BRANCH,
        EXEC_JUMP
    } exec_class_t;

    // ALU ops take rs1_value and rs2_value as their two operands.
    // Jumps target rs1_value + immediate and write back pc + 4
    typedef struct packed {
        reg_value_t  pc;
        exec_class_t op_class;
        logic [2:0]  funct3;
        logic        alt;
        reg_value_t  rs1_value;
        reg_value_t  rs2_value;
        reg_value_t  immediate;
        reg_addr_t   rd_addr;
        logic        halt;
    } execute_op_t;

    typedef struct packed {
        logic       is_store;
        logic [2:0] funct3;
        reg_value_t rs1_value;
        reg_value_t rs2_value;
        reg_value_t immediate;
        reg_addr_t  rd_addr;
    } system_op_t;

    function automatic execute_op_t create_execute_op(
        input instr_t     instr,
        input reg_value_t pc,
        input reg_value_t rs1_value,
        input reg_value_t rs2_value,
        input logic       halt
    );
        rv_fields_t  f;
        execute_op_t op;
        f = get_fields(instr);
        op.pc        = pc;
        op.op_class  = EXEC_ALU;
        op.funct3    = f.funct3;
        op.alt       = 1'b0;
        // Unused operands are zeroed so the payload never carries stale data
        op.rs1_value = uses_rs1(f) ? rs1_value : '0;
        op.rs2_value = uses_rs2(f) ? rs2_value : '0;
        op.immediate = get_immediate(instr);
        op.rd_addr   = writes_rd(f) ? f.rd : '0;
        op.halt      = halt;
        case (f.opcode)
            RV_OP:     op.alt = instr[30];
            RV_OP_IMM: begin
                // Only SRAI uses bit 30 as an opcode bit
                op.alt       = (f.funct3 == 3'b101) && instr[30];
                op.rs2_value = op.immediate;
            end
            RV_LUI: begin
                op.funct3    = 3'b000;
                op.rs2_value = op.immediate;
            end
            RV_AUIPC: begin
                op.funct3    = 3'b000;
                op.rs1_value = pc;
                op.rs2_value = op.immediate;
            end
            RV_BRANCH: op.op_class = EXEC_BRANCH;
            RV_JAL: begin
                op.op_class  = EXEC_JUMP;
                op.rs1_value = pc;
            end
            RV_JALR:   op.op_class = EXEC_JUMP;
            default:   op.op_class = EXEC_ALU;
        endcase
        if (halt) begin
            op.op_class = EXEC_JUMP;
            op.rd_addr  = '0;
        end
        return op;
    endfunction

    function automatic system_op_t create_system_op(
        input instr_t     instr,
        input reg_value_t rs1_value,
        input reg_value_t rs2_value
    );
        rv_fields_t f;
        system_op_t op;
        f = get_fields(instr);
        op.is_store  = (f.opcode == RV_STORE);
        op.funct3    = f.funct3;
        op.rs1_value = rs1_value;
        op.rs2_value = op.is_store ? rs2_value : '0;
        op.immediate = get_immediate(instr);
        op.rd_addr   = writes_rd(f) ? f.rd : '0;
        return op;
    endfunction

    function automatic logic op_is_control_flow(input rv_fields_t f);
        return f.opcode inside {RV_BRANCH, RV_JAL, RV_JALR};
    endfunction

    // Float, fence, unknown opcodes and M extension ops all count as illegal
    function automatic logic op_is_illegal(input instr_t instr);
        rv_fields_t f;
        f = get_fields(instr);
        case (f.opcode)
            RV_OP:     return f.funct7 == 7'd1;
            RV_SYSTEM: return instr != EBREAK_INSTR;
            RV_OP_IMM, RV_LUI, RV_AUIPC, RV_BRANCH, RV_JAL, RV_JALR, RV_LOAD, RV_STORE:
                return 1'b0;
            default:   return 1'b1;
        endcase
    endfunction

endpackage

// ==== regfile_intf.sv ====
`timescale 1ns/1ns

interface regfile_intf
    import rv_isa_pkg::*;
(
    input logic clk
);

    // Operand reads
    reg_addr_t  rs1_addr, rs2_addr;
    reg_value_t rs1_value, rs2_value;
    logic       rs1_ready, rs2_ready;

    // Destination reservation
    logic       reserve_enable;
    reg_addr_t  reserve_addr;
    logic       rd_can_reserve;

    // Writeback from the later stages
    logic       write_enable;
    reg_addr_t  write_addr;
    reg_value_t write_value;

    modport controller (
        input  clk,
        output rs1_addr, rs2_addr, reserve_enable, reserve_addr,
        input  rs1_value, rs2_value, rs1_ready, rs2_ready, rd_can_reserve
    );

    modport regfile (
        input  clk,
        input  rs1_addr, rs2_addr, reserve_enable, reserve_addr,
        input  write_enable, write_addr, write_value,
        output rs1_value, rs2_value, rs1_ready, rs2_ready, rd_can_reserve
    );

endinterface

// ==== decode_regfile.sv ====
`timescale 1ns/1ns

module decode_regfile
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic clk,
    input  logic rst,

    regfile_intf.regfile rf,

    output logic reset_done
);

    reg_value_t  values [NUM_REGS];
    reg_status_t front  [NUM_REGS];
    reg_status_t rear   [NUM_REGS];
    reg_addr_t   clear_addr;
    logic        write_hit;

    assign write_hit = rf.write_enable && (rf.write_addr != '0);

    // Walk every register once after reset to zero it
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_addr <= '0;
            reset_done <= 1'b0;
        end else if (!reset_done) begin
            clear_addr <= clear_addr + 1'b1;
            if (clear_addr == reg_addr_t'(NUM_REGS - 1)) begin
                reset_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_done) begin
            values[clear_addr] <= '0;
        end else if (write_hit) begin
            values[rf.write_addr] <= rf.write_value;
        end
    end

    // Front counts reservations, rear counts retired writes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                front[i] <= '0;
                rear[i]  <= '0;
            end
        end else begin
            if (rf.reserve_enable && rf.reserve_addr != '0) begin
                front[rf.reserve_addr] <= reg_status_t'(front[rf.reserve_addr] + 1'b1);
            end
            if (write_hit) begin
                rear[rf.write_addr] <= reg_status_t'(rear[rf.write_addr] + 1'b1);
            end
        end
    end

    always_comb begin
        rf.rs1_value = values[rf.rs1_addr];
        rf.rs2_value = values[rf.rs2_addr];
        rf.rs1_ready = (front[rf.rs1_addr] == rear[rf.rs1_addr]);
        rf.rs2_ready = (front[rf.rs2_addr] == rear[rf.rs2_addr]);
        // One more reservation must not wrap front onto rear
        rf.rd_can_reserve =
            (reg_status_t'(front[rf.reserve_addr] + 1'b1) != rear[rf.reserve_addr]);
    end

endmodule

// ==== decode_control.sv ====
`timescale 1ns/1ns

module decode_control
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    regfile_intf.controller rf,
    input  logic        reset_done,

    input  logic        instr_valid,
    output logic        instr_ready,
    input  instr_t      instr_data,
    input  reg_value_t  instr_pc,
    input  jump_flag_t  instr_jump_flag,

    input  logic        jump_valid,
    input  logic        jump_mispredict,

    output logic        exec_valid,
    input  logic        exec_ready,
    output execute_op_t exec_op,

    output logic        sys_valid,
    input  logic        sys_ready,
    output system_op_t  sys_op,

    output logic        exit_flag,
    output logic        error_flag
);

    decode_state_t state, next_state;
    jump_flag_t    jump_flag, next_jump_flag;
    logic          cf_pending;
    rv_fields_t    fields;

    logic cf_blocked;
    logic flag_stale;
    logic illegal;
    logic halt;
    logic to_system;
    logic hazard;
    logic target_ready;
    logic issue;

    always_comb begin
        fields = get_fields(instr_data);

        rf.rs1_addr     = fields.rs1;
        rf.rs2_addr     = fields.rs2;
        rf.reserve_addr = fields.rd;

        // A jump strobe counts in this same cycle
        next_jump_flag = (jump_valid && jump_mispredict) ?
                         jump_flag_t'(jump_flag + 1'b1) : jump_flag;
        cf_blocked     = cf_pending && !jump_valid;
        flag_stale     = (instr_jump_flag != next_jump_flag);

        illegal   = op_is_illegal(instr_data);
        halt      = illegal || (instr_data == EBREAK_INSTR);
        to_system = !halt && (fields.opcode inside {RV_LOAD, RV_STORE});

        // Halting ops never touch the scoreboard
        hazard = !halt && ((uses_rs1(fields) && !rf.rs1_ready) ||
                           (uses_rs2(fields) && !rf.rs2_ready) ||
                           (writes_rd(fields) && !rf.rd_can_reserve));
        target_ready = to_system ? sys_ready : exec_ready;

        instr_ready = 1'b0;
        issue       = 1'b0;
        case (state)
            DECODE_NORMAL: begin
                if (flag_stale) begin
                    // Fetched down the wrong path
                    instr_ready = 1'b1;
                end else if (!hazard && !cf_blocked) begin
                    instr_ready = target_ready;
                    issue       = instr_valid && target_ready;
                end
            end
            DECODE_EXIT: instr_ready = 1'b1;
            default:     instr_ready = 1'b0;
        endcase

        rf.reserve_enable = issue && !halt && writes_rd(fields);

        exec_valid = issue && !to_system;
        sys_valid  = issue && to_system;
        exec_op    = create_execute_op(instr_data, instr_pc, rf.rs1_value, rf.rs2_value, halt);
        sys_op     = create_system_op(instr_data, rf.rs1_value, rf.rs2_value);

        case (state)
            DECODE_RESET:  next_state = reset_done ? DECODE_NORMAL : DECODE_RESET;
            DECODE_NORMAL: next_state = (issue && halt) ? DECODE_EXIT : DECODE_NORMAL;
            DECODE_EXIT:   next_state = DECODE_EXIT;
            default:       next_state = DECODE_RESET;
        endcase

        exit_flag = (state == DECODE_EXIT);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= DECODE_RESET;
            jump_flag  <= '0;
            cf_pending <= 1'b0;
            error_flag <= 1'b0;
        end else begin
            state     <= next_state;
            jump_flag <= next_jump_flag;
            // A new branch wins over the strobe that resolves the old one
            if (issue && !halt && op_is_control_flow(fields)) begin
                cf_pending <= 1'b1;
            end else if (jump_valid) begin
                cf_pending <= 1'b0;
            end
            if (issue && illegal) begin
                error_flag <= 1'b1;
            end
        end
    end

endmodule

// ==== op_output_stage.sv ====
`timescale 1ns/1ns

module op_output_stage #(
    parameter type T = logic [31:0],
    parameter bit PIPELINE_REGISTERED = 1'b1
)(
    input  logic clk,
    input  logic rst,

    input  logic in_valid,
    output logic in_ready,
    input  T     in_payload,

    output logic out_valid,
    input  logic out_ready,
    output T     out_payload
);

    generate
        if (PIPELINE_REGISTERED) begin : g_registered
            logic full;
            T     held;

            // Refill in the same cycle the held item leaves
            assign in_ready    = !full || out_ready;
            assign out_valid   = full;
            assign out_payload = held;

            always_ff @(posedge clk) begin
                if (rst) begin
                    full <= 1'b0;
                end else if (in_ready) begin
                    full <= in_valid;
                end
            end

            always_ff @(posedge clk) begin
                if (in_valid && in_ready) begin
                    held <= in_payload;
                end
            end
        end else begin : g_bypass
            assign in_ready    = out_ready;
            assign out_valid   = in_valid;
            assign out_payload = in_payload;
        end
    endgenerate

endmodule

// ==== decode_top.sv ====
`timescale 1ns/1ns

module decode_top
    import rv_isa_pkg::*;
    import decode_pkg::*;
#(
    parameter bit OUTPUT_REGISTERED = 1'b1
)(
    input  logic        clk,
    input  logic        rst,

    input  logic        instr_valid,
    output logic        instr_ready,
    input  instr_t      instr_data,
    input  reg_value_t  instr_pc,
    input  jump_flag_t  instr_jump_flag,

    output logic        exec_valid,
    input  logic        exec_ready,
    output execute_op_t exec_op,

    output logic        sys_valid,
    input  logic        sys_ready,
    output system_op_t  sys_op,

    input  logic        wb_valid,
    input  reg_addr_t   wb_addr,
    input  reg_value_t  wb_value,

    input  logic        jump_valid,
    input  logic        jump_mispredict,

    output logic        exit_flag,
    output logic        error_flag
);

    logic        reset_done;

    logic        next_exec_valid, next_exec_ready;
    execute_op_t next_exec_op;
    logic        next_sys_valid, next_sys_ready;
    system_op_t  next_sys_op;

    regfile_intf rf (.clk);

    // Writeback strobe goes straight into the register file
    assign rf.write_enable = wb_valid;
    assign rf.write_addr   = wb_addr;
    assign rf.write_value  = wb_value;

    decode_regfile regfile_inst (
        .clk,
        .rst,
        .rf,
        .reset_done
    );

    decode_control control_inst (
        .clk,
        .rst,
        .rf,
        .reset_done,
        .instr_valid,
        .instr_ready,
        .instr_data,
        .instr_pc,
        .instr_jump_flag,
        .jump_valid,
        .jump_mispredict,
        .exec_valid (next_exec_valid),
        .exec_ready (next_exec_ready),
        .exec_op    (next_exec_op),
        .sys_valid  (next_sys_valid),
        .sys_ready  (next_sys_ready),
        .sys_op     (next_sys_op),
        .exit_flag,
        .error_flag
    );

    op_output_stage #(
        .T                   (execute_op_t),
        .PIPELINE_REGISTERED (OUTPUT_REGISTERED)
    ) exec_stage_inst (
        .clk,
        .rst,
        .in_valid    (next_exec_valid),
        .in_ready    (next_exec_ready),
        .in_payload  (next_exec_op),
        .out_valid   (exec_valid),
        .out_ready   (exec_ready),
        .out_payload (exec_op)
    );

    op_output_stage #(
        .T                   (system_op_t),
        .PIPELINE_REGISTERED (OUTPUT_REGISTERED)
    ) sys_stage_inst (
        .clk,
        .rst,
        .in_valid    (next_sys_valid),
        .in_ready    (next_sys_ready),
        .in_payload  (next_sys_op),
        .out_valid   (sys_valid),
        .out_ready   (sys_ready),
        .out_payload (sys_op)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
)(
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule

// ==== tb_decode.sv ====
`timescale 1ns/1ns

module tb_decode
    import rv_isa_pkg::*;
    import decode_pkg::*;
();

    localparam int     NUM_INSTR   = 300;
    localparam int     WAIT_LIMIT  = 200;
    localparam instr_t EBREAK_WORD = 32'h0010_0073;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic        instr_ready;
    instr_t      instr_data;
    reg_value_t  instr_pc;
    jump_flag_t  instr_jump_flag;
    logic        exec_valid;
    logic        exec_ready;
    execute_op_t exec_op;
    logic        sys_valid;
    logic        sys_ready;
    system_op_t  sys_op;
    logic        wb_valid;
    reg_addr_t   wb_addr;
    reg_value_t  wb_value;
    logic        jump_valid;
    logic        jump_mispredict;
    logic        exit_flag;
    logic        error_flag;

    logic [31:0] lfsr;
    int          value_errors;
    int          other_errors;
    reg_value_t  next_pc;
    logic        cur_halt;
    logic        cur_illegal;

    // Reference model
    reg_value_t  m_regs [32];
    int          m_pend [32];
    reg_addr_t   m_wb_fifo [$];
    execute_op_t m_exec_q [$];
    system_op_t  m_sys_q [$];
    jump_flag_t  m_flag;
    logic        m_cf;
    logic        m_exit;
    logic        m_error;

    tb_clock_gen #(.PERIOD_NS(40)) clock_gen_inst (.clk);

    decode_top #(.OUTPUT_REGISTERED(1'b1)) DUT (
        .clk, .rst,
        .instr_valid, .instr_ready, .instr_data, .instr_pc, .instr_jump_flag,
        .exec_valid, .exec_ready, .exec_op,
        .sys_valid, .sys_ready, .sys_op,
        .wb_valid, .wb_addr, .wb_value,
        .jump_valid, .jump_mispredict,
        .exit_flag, .error_flag
    );

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] next_random(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = b ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic instr_t make_instr();
        instr_t     w;
        logic [6:0] opc;
        w = next_random(32);
        // Only x0..x7 so that operands collide often
        w[11:7]  = reg_addr_t'(next_random(3));
        w[19:15] = reg_addr_t'(next_random(3));
        w[24:20] = reg_addr_t'(next_random(3));
        case (next_random(4) % 9)
            0:       opc = RV_OP;
            1:       opc = RV_LUI;
            2:       opc = RV_AUIPC;
            3:       opc = RV_BRANCH;
            4:       opc = RV_JAL;
            5:       opc = RV_JALR;
            6:       opc = RV_LOAD;
            7:       opc = RV_STORE;
            default: opc = RV_OP_IMM;
        endcase
        w[6:0] = opc;
        if (opc == RV_OP) begin
            w[31:25] = {1'b0, w[30], 5'b0};
        end
        return w;
    endfunction

    task automatic drive_random();
        exec_ready      = (next_random(2) != 0);
        sys_ready       = (next_random(2) != 0);
        wb_valid        = 1'b0;
        jump_valid      = 1'b0;
        jump_mispredict = 1'b0;
        // Writebacks retire in issue order
        if (m_wb_fifo.size() > 0 && next_random(1) == 1) begin
            wb_valid = 1'b1;
            wb_addr  = m_wb_fifo[0];
            wb_value = next_random(32);
        end
        if (m_cf && next_random(2) == 0) begin
            jump_valid      = 1'b1;
            jump_mispredict = (next_random(1) == 1);
        end
    endtask

    task automatic check_outputs();
        execute_op_t e;
        system_op_t  s;
        assert (exit_flag == m_exit) else begin
            $display("Fail exit_flag got %h expected %h", exit_flag, m_exit);
            value_errors++;
        end
        assert (error_flag == m_error) else begin
            $display("Fail error_flag got %h expected %h", error_flag, m_error);
            value_errors++;
        end
        if (exec_valid && exec_ready) begin
            assert (m_exec_q.size() > 0) else begin
                $display("Execute op arrived when none was expected");
                other_errors++;
            end
            if (m_exec_q.size() > 0) begin
                e = m_exec_q.pop_front();
                assert (exec_op == e) else begin
                    $display("Fail exec_op got %h expected %h", exec_op, e);
                    value_errors++;
                end
            end
        end
        if (sys_valid && sys_ready) begin
            assert (m_sys_q.size() > 0) else begin
                $display("System op arrived when none was expected");
                other_errors++;
            end
            if (m_sys_q.size() > 0) begin
                s = m_sys_q.pop_front();
                assert (sys_op == s) else begin
                    $display("Fail sys_op got %h expected %h", sys_op, s);
                    value_errors++;
                end
            end
        end
    endtask

    task automatic model_accept(output logic issued_cf);
        rv_fields_t f;
        jump_flag_t next_flag;
        logic       pending;
        f = get_fields(instr_data);
        next_flag = (jump_valid && jump_mispredict) ? jump_flag_t'(m_flag + 1'b1) : m_flag;
        issued_cf = 1'b0;
        // Wrong-path words and anything after exit are dropped
        if (m_exit || instr_jump_flag != next_flag) begin
            return;
        end
        pending = (uses_rs1(f) && m_pend[f.rs1] != 0) || (uses_rs2(f) && m_pend[f.rs2] != 0);
        assert (!m_cf || jump_valid) else begin
            $display("Instruction at pc %h issued before the branch resolved", instr_pc);
            other_errors++;
        end
        assert (cur_halt || !pending) else begin
            $display("Instruction at pc %h issued while an operand write was pending", instr_pc);
            other_errors++;
        end
        if (!cur_halt && f.opcode inside {RV_LOAD, RV_STORE}) begin
            m_sys_q.push_back(create_system_op(instr_data, m_regs[f.rs1], m_regs[f.rs2]));
        end else begin
            m_exec_q.push_back(create_execute_op(instr_data, instr_pc,
                                                 m_regs[f.rs1], m_regs[f.rs2], cur_halt));
        end
        if (cur_halt) begin
            m_exit  = 1'b1;
            m_error = cur_illegal;
        end else begin
            if (writes_rd(f)) begin
                m_wb_fifo.push_back(f.rd);
                m_pend[f.rd]++;
            end
            issued_cf = f.opcode inside {RV_BRANCH, RV_JAL, RV_JALR};
        end
    endtask

    // Sample mid-cycle and update the model before the edge, then drive after it
    task automatic run_cycle(output logic acc);
        logic issued_cf;
        @(negedge clk);
        check_outputs();
        acc = instr_valid && instr_ready;
        issued_cf = 1'b0;
        if (acc) begin
            model_accept(issued_cf);
        end
        if (issued_cf) begin
            m_cf = 1'b1;
        end else if (jump_valid) begin
            m_cf = 1'b0;
        end
        if (jump_valid && jump_mispredict) begin
            m_flag = jump_flag_t'(m_flag + 1'b1);
        end
        if (wb_valid) begin
            m_regs[wb_addr] = wb_value;
            m_pend[wb_addr]--;
            void'(m_wb_fifo.pop_front());
        end
        @(posedge clk);
        #5;
        drive_random();
    endtask

    task automatic send_instr(input instr_t w, input logic halt, input logic illegal);
        int   n;
        logic acc;
        cur_halt        = halt;
        cur_illegal     = illegal;
        instr_valid     = 1'b1;
        instr_data      = w;
        instr_pc        = next_pc;
        // Now and then a word from the wrong path
        instr_jump_flag = (!halt && next_random(3) == 0) ? jump_flag_t'(m_flag - 1'b1) : m_flag;
        next_pc         = next_pc + 32'd4;
        n   = 0;
        acc = 1'b0;
        while (!acc && n < WAIT_LIMIT) begin
            run_cycle(acc);
            n++;
        end
        assert (acc) else begin
            $display("Timeout waiting for the instruction at pc %h to be taken", instr_pc);
            other_errors++;
        end
        instr_valid = 1'b0;
    endtask

    task automatic apply_reset();
        rst             = 1'b1;
        instr_valid     = 1'b0;
        instr_data      = 32'h0000_0013;
        instr_pc        = '0;
        instr_jump_flag = '0;
        exec_ready      = 1'b1;
        sys_ready       = 1'b1;
        wb_valid        = 1'b0;
        wb_addr         = '0;
        wb_value        = '0;
        jump_valid      = 1'b0;
        jump_mispredict = 1'b0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
            m_pend[i] = 0;
        end
        m_wb_fifo.delete();
        m_exec_q.delete();
        m_sys_q.delete();
        m_flag  = '0;
        m_cf    = 1'b0;
        m_exit  = 1'b0;
        m_error = 1'b0;
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        assert (!exec_valid && !sys_valid && !instr_ready && !exit_flag && !error_flag) else begin
            $display("Outputs were not all low after reset");
            other_errors++;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!instr_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (instr_ready) else begin
            $display("Timeout waiting for instr_ready after reset");
            other_errors++;
        end
        @(posedge clk);
        #5;
    endtask

    task automatic drain();
        int   n;
        logic acc;
        n = 0;
        while ((m_exec_q.size() > 0 || m_sys_q.size() > 0 || m_wb_fifo.size() > 0) &&
               n < WAIT_LIMIT) begin
            run_cycle(acc);
            n++;
        end
        assert (n < WAIT_LIMIT) else begin
            $display("Timeout waiting for the outputs and writebacks to drain");
            other_errors++;
        end
        // A few quiet cycles to catch stray ops
        repeat (4) run_cycle(acc);
    endtask

    task automatic run_phase(input logic end_illegal);
        instr_t w;
        int     tries;
        apply_reset();
        wait_ready();
        for (int i = 0; i < NUM_INSTR; i++) begin
            send_instr(make_instr(), 1'b0, 1'b0);
        end
        w = EBREAK_WORD;
        if (end_illegal) begin
            // MUL is outside RV32I
            w        = make_instr();
            w[6:0]   = RV_OP;
            w[31:25] = 7'd1;
        end
        tries = 0;
        while (!m_exit && tries < 8) begin
            send_instr(w, 1'b1, end_illegal);
            tries++;
        end
        assert (m_exit) else begin
            $display("Halting instruction was never issued");
            other_errors++;
        end
        for (int i = 0; i < 4; i++) begin
            send_instr(make_instr(), 1'b0, 1'b0);
        end
        drain();
        assert (exit_flag == 1'b1) else begin
            $display("Fail exit_flag got %h expected %h", exit_flag, 1'b1);
            value_errors++;
        end
        assert (error_flag == end_illegal) else begin
            $display("Fail error_flag got %h expected %h", error_flag, end_illegal);
            value_errors++;
        end
    endtask

    initial begin
        lfsr         = 32'hc620_5089;
        value_errors = 0;
        other_errors = 0;
        next_pc      = 32'h0000_1000;
        cur_halt     = 1'b0;
        cur_illegal  = 1'b0;
        run_phase(1'b1);
        run_phase(1'b0);
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rv_isa_pkg.sv
decode_pkg.sv
regfile_intf.sv
decode_regfile.sv
decode_control.sv
op_output_stage.sv
decode_top.sv
tb_clock_gen.sv
tb_decode.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_decode -f src.f > build.log 2>&1 &&
    ./obj_dir/Vtb_decode > sim.log 2>&1 ||
    { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
